//--- list.f
source/ntm_pkg.sv
source/ntm_mem_pkg.sv
source/ntm_memory.sv
source/ntm_memory_arbiter.sv
source/ntm_reading.sv
source/ntm_writing.sv
source/ntm_head_top.sv
verif/ntm_head_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the NTM memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f \
  --top-module ntm_head_tb -Mdir obj_dir -o ntm_head_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ntm_head_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "No pass line in $LOG"
  exit 1
fi
exit 0

//--- verif/ntm_head_tb.sv
`default_nettype none

module ntm_head_tb;
  import ntm_pkg::*;

  // Cycles allowed for any single wait
  localparam int TIMEOUT = 2000;

  logic    CLK;
  logic    RST;
  logic    read_start;
  weight_t read_weight;
  logic    read_ready;
  data_t   r_out;
  logic    r_out_enable;
  logic    write_start;
  weight_t write_weight;
  vector_t write_add;
  logic    write_ready;

  // Shadow of M and expected read vector
  data_t shadow [N_ROWS][W_COLS];
  data_t exp_r  [W_COLS];
  data_t exp_now;

  // Monitor state
  int   strobe_cnt;
  int   rd_done;
  int   wr_done;
  logic rd_busy;

  // READY pulses expected so far
  int rd_target;
  int wr_target;

  int   assert_fails = 0;
  int   check_fails;
  int   test_base;
  int   n_tests;
  int   seed;
  logic quiet_chk;
  logic [2:0] idle_outs;

  ntm_head_top DUT (
    .CLK          (CLK),
    .RST          (RST),
    .read_start   (read_start),
    .read_weight  (read_weight),
    .read_ready   (read_ready),
    .r_out        (r_out),
    .r_out_enable (r_out_enable),
    .write_start  (write_start),
    .write_weight (write_weight),
    .write_add    (write_add),
    .write_ready  (write_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and checks
  ////////////////////////////////////////////////////////////////////////////

  // Strobes per read, READY pulses per head
  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_busy    <= 1'b0;
      strobe_cnt <= 0;
      rd_done    <= 0;
      wr_done    <= 0;
    end else begin
      // Start only counts on an idle head
      if (read_start && !rd_busy) begin
        rd_busy    <= 1'b1;
        strobe_cnt <= 0;
      end else if (r_out_enable) begin
        strobe_cnt <= strobe_cnt + 1;
      end
      if (read_ready) begin
        rd_busy <= 1'b0;
        rd_done <= rd_done + 1;
      end
      if (write_ready) begin
        wr_done <= wr_done + 1;
      end
    end
  end

  // Column the next strobe should carry
  always_comb begin
    exp_now = '0;
    if (strobe_cnt < W_COLS) begin
      exp_now = exp_r[col_idx_t'(strobe_cnt)];
    end
  end

  assign idle_outs = {read_ready, write_ready, r_out_enable};

  assert property (@(posedge CLK) disable iff (RST)
    r_out_enable |-> (strobe_cnt < W_COLS) && (r_out == exp_now))
  else begin
    $display("CHECK FAILED: r_out got %h expected %h", $sampled(r_out), $sampled(exp_now));
    assert_fails++;
  end

  // All columns out before READY
  assert property (@(posedge CLK) disable iff (RST)
    read_ready |-> (strobe_cnt == W_COLS))
  else begin
    $display("CHECK FAILED: strobe_cnt got %h expected %h", $sampled(strobe_cnt), W_COLS);
    assert_fails++;
  end

  assert property (@(posedge CLK) disable iff (RST) read_ready |=> !read_ready)
  else begin
    $display("CHECK FAILED: read_ready got %h expected %h", 1'b1, 1'b0);
    assert_fails++;
  end

  assert property (@(posedge CLK) disable iff (RST) write_ready |=> !write_ready)
  else begin
    $display("CHECK FAILED: write_ready got %h expected %h", 1'b1, 1'b0);
    assert_fails++;
  end

  // Quiet outputs after reset
  assert property (@(posedge CLK) disable iff (RST) quiet_chk |-> (idle_outs == 3'b000))
  else begin
    $display("CHECK FAILED: idle_outs got %h expected %h", $sampled(idle_outs), 3'b000);
    assert_fails++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers and model
  ////////////////////////////////////////////////////////////////////////////

  task automatic rand_word(output data_t v);
    logic [31:0] r;
    r = $random(seed);
    v = r[15:0];
  endtask

  // Random weights on rows lo..hi, zero elsewhere
  task automatic rand_weight(input int lo, input int hi, output weight_t w);
    data_t v;
    w = '0;
    for (int j = lo; j <= hi; j++) begin
      rand_word(v);
      w.elem[row_idx_t'(j)] = v;
    end
  endtask

  task automatic rand_vector(output vector_t a);
    data_t v;
    for (int k = 0; k < W_COLS; k++) begin
      rand_word(v);
      a.elem[col_idx_t'(k)] = v;
    end
  endtask

  function automatic weight_t one_hot(input int j);
    weight_t w;
    w = '0;
    w.elem[row_idx_t'(j)] = 16'd1;
    return w;
  endfunction

  // M[j][k] += w[j]*a[k], 16 bit wrap
  task automatic model_write(input weight_t w, input vector_t a);
    for (int j = 0; j < N_ROWS; j++) begin
      for (int k = 0; k < W_COLS; k++) begin
        shadow[j][k] = shadow[j][k] + w.elem[row_idx_t'(j)] * a.elem[col_idx_t'(k)];
      end
    end
  endtask

  // r[k] = sum of w[j]*M[j][k]
  task automatic model_read(input weight_t w);
    data_t acc;
    for (int k = 0; k < W_COLS; k++) begin
      acc = '0;
      for (int j = 0; j < N_ROWS; j++) begin
        acc = acc + w.elem[row_idx_t'(j)] * shadow[j][k];
      end
      exp_r[k] = acc;
    end
  endtask

  // One START pulse on either or both heads
  task automatic launch(input logic do_rd, input weight_t rw,
                        input logic do_wr, input weight_t ww, input vector_t a);
    if (do_rd) begin
      model_read(rw);
      rd_target++;
    end
    if (do_wr) begin
      model_write(ww, a);
      wr_target++;
    end
    @(posedge CLK);
    read_start   <= do_rd;
    read_weight  <= rw;
    write_start  <= do_wr;
    write_weight <= ww;
    write_add    <= a;
    @(posedge CLK);
    read_start  <= 1'b0;
    write_start <= 1'b0;
  endtask

  task automatic wait_done();
    int cyc;
    cyc = 0;
    while ((rd_done != rd_target || wr_done != wr_target) && cyc < TIMEOUT) begin
      @(posedge CLK);
      cyc++;
    end
    if (rd_done != rd_target || wr_done != wr_target) begin
      $display("Timeout: a head did not raise READY within %0d cycles", TIMEOUT);
      check_fails++;
    end
    // Extra READY pulses would show here
    repeat (4) @(posedge CLK);
    assert (rd_done == rd_target) else begin
      $display("CHECK FAILED: rd_done got %h expected %h", rd_done, rd_target);
      check_fails++;
    end
    assert (wr_done == wr_target) else begin
      $display("CHECK FAILED: wr_done got %h expected %h", wr_done, wr_target);
      check_fails++;
    end
  endtask

  task automatic end_test(input string name);
    int now_fails;
    now_fails = check_fails + assert_fails;
    n_tests++;
    $display("Test %0d (%s) done with %0d errors", n_tests, name, now_fails - test_base);
    test_base = now_fails;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    weight_t w;
    weight_t rw;
    vector_t a;
    int      total;
    seed         = 32'h7815_a05d;
    check_fails  = 0;
    test_base    = 0;
    n_tests      = 0;
    rd_target    = 0;
    wr_target    = 0;
    RST          <= 1'b1;
    read_start   <= 1'b0;
    read_weight  <= '0;
    write_start  <= 1'b0;
    write_weight <= '0;
    write_add    <= '0;
    quiet_chk    <= 1'b0;
    for (int j = 0; j < N_ROWS; j++) begin
      for (int k = 0; k < W_COLS; k++) begin
        shadow[j][k] = '0;
      end
    end
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // Idle outputs, zero memory
    quiet_chk <= 1'b1;
    repeat (8) @(posedge CLK);
    quiet_chk <= 1'b0;
    rand_weight(0, N_ROWS - 1, w);
    launch(1'b1, w, 1'b0, '0, '0);
    wait_done();
    end_test("reset state");

    // One-hot write then one-hot read of row 5
    rand_vector(a);
    launch(1'b0, '0, 1'b1, one_hot(5), a);
    wait_done();
    launch(1'b1, one_hot(5), 1'b0, '0, '0);
    wait_done();
    end_test("one-hot row");

    // Large weights force wraparound
    w = '0;
    w.elem[1] = 16'hFFFF;
    w.elem[2] = 16'h8001;
    for (int i = 0; i < 3; i++) begin
      rand_vector(a);
      launch(1'b0, '0, 1'b1, w, a);
      wait_done();
    end
    rand_weight(0, N_ROWS - 1, rw);
    launch(1'b1, rw, 1'b0, '0, '0);
    wait_done();
    end_test("accumulate");

    // Both heads at once on disjoint rows
    rand_weight(0, 3, w);
    rand_weight(4, N_ROWS - 1, rw);
    rand_vector(a);
    launch(1'b1, rw, 1'b1, w, a);
    wait_done();
    end_test("concurrent heads");

    // Second START while busy, new operands must be ignored
    rand_weight(0, N_ROWS - 1, rw);
    launch(1'b1, rw, 1'b0, '0, '0);
    repeat (3) @(posedge CLK);
    read_start  <= 1'b1;
    read_weight <= ~rw;
    @(posedge CLK);
    read_start <= 1'b0;
    wait_done();
    rand_weight(0, N_ROWS - 1, w);
    rand_vector(a);
    launch(1'b0, '0, 1'b1, w, a);
    repeat (3) @(posedge CLK);
    write_start <= 1'b1;
    write_add   <= ~a;
    @(posedge CLK);
    write_start <= 1'b0;
    wait_done();
    rand_weight(0, N_ROWS - 1, rw);
    launch(1'b1, rw, 1'b0, '0, '0);
    wait_done();
    end_test("start while busy");

    for (int i = 0; i < 20; i++) begin
      rand_weight(0, N_ROWS - 1, w);
      rand_vector(a);
      launch(1'b0, '0, 1'b1, w, a);
      wait_done();
      rand_weight(0, N_ROWS - 1, rw);
      launch(1'b1, rw, 1'b0, '0, '0);
      wait_done();
    end
    end_test("random rounds");

    total = check_fails + assert_fails;
    $display("Done: %0d tests, %0d errors", n_tests, total);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/ntm_head_top.sv
`default_nettype none

module ntm_head_top (
  input  wire logic             CLK,
  input  wire logic             RST,
  // Read head
  input  wire logic             read_start,
  input  wire ntm_pkg::weight_t read_weight,
  output logic                  read_ready,
  output ntm_pkg::data_t        r_out,
  output logic                  r_out_enable,
  // Write head
  input  wire logic             write_start,
  input  wire ntm_pkg::weight_t write_weight,
  input  wire ntm_pkg::vector_t write_add,
  output logic                  write_ready
);
  import ntm_mem_pkg::*;

  // Head side buses
  mem_req_t rd_req;
  mem_req_t wr_req;
  mem_rsp_t rd_rsp;
  mem_rsp_t wr_rsp;
  logic     rd_gnt;
  logic     wr_gnt;

  // Memory side bus
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  ntm_reading reading (
    .CLK          (CLK),
    .RST          (RST),
    .start        (read_start),
    .weight       (read_weight),
    .ready        (read_ready),
    .mem_req      (rd_req),
    .gnt          (rd_gnt),
    .mem_rsp      (rd_rsp),
    .r_out        (r_out),
    .r_out_enable (r_out_enable)
  );

  ntm_writing writing (
    .CLK     (CLK),
    .RST     (RST),
    .start   (write_start),
    .weight  (write_weight),
    .add     (write_add),
    .ready   (write_ready),
    .mem_req (wr_req),
    .gnt     (wr_gnt),
    .mem_rsp (wr_rsp)
  );

  // One bus access per cycle, shared
  ntm_memory_arbiter arbiter (
    .CLK     (CLK),
    .RST     (RST),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_gnt  (rd_gnt),
    .wr_gnt  (wr_gnt),
    .rd_rsp  (rd_rsp),
    .wr_rsp  (wr_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  ntm_memory memory (
    .CLK     (CLK),
    .RST     (RST),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

`default_nettype wire

//--- source/ntm_writing.sv
`default_nettype none

module ntm_writing (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire ntm_pkg::weight_t      weight,
  input  wire ntm_pkg::vector_t      add,
  output logic                       ready,
  output ntm_mem_pkg::mem_req_t      mem_req,
  input  wire logic                  gnt,
  input  wire ntm_mem_pkg::mem_rsp_t mem_rsp
);
  import ntm_pkg::*;
  import ntm_mem_pkg::*;

  // M[j][k] <= M[j][k] + w[j] * a[k]

  // Control
  head_state_e state_q;
  row_idx_t    row_q;
  col_idx_t    col_q;

  // Data path
  weight_t w_q;
  vector_t a_q;
  data_t   upd_q;
  data_t   upd_next;

  // Old word plus weighted add term, wraps at 16 bits
  assign upd_next = mem_rsp.rdata + w_q.elem[row_q] * a_q.elem[col_q];

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= HEAD_IDLE;
      row_q   <= '0;
      col_q   <= '0;
      ready   <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state_q)
        HEAD_IDLE: begin
          if (start) begin
            row_q   <= '0;
            col_q   <= '0;
            state_q <= HEAD_REQ;
          end
        end
        // Fetch old word
        HEAD_REQ: begin
          if (gnt) begin
            state_q <= HEAD_WAIT;
          end
        end
        HEAD_WAIT: begin
          if (mem_rsp.rvalid) begin
            state_q <= HEAD_WRITE;
          end
        end
        // Write back, then step column first, row second
        HEAD_WRITE: begin
          if (gnt) begin
            if (row_q == LAST_ROW && col_q == LAST_COL) begin
              ready   <= 1'b1;
              state_q <= HEAD_DONE;
            end else begin
              if (col_q == LAST_COL) begin
                col_q <= '0;
                row_q <= row_q + 1'b1;
              end else begin
                col_q <= col_q + 1'b1;
              end
              state_q <= HEAD_REQ;
            end
          end
        end
        HEAD_DONE: state_q <= HEAD_IDLE;
        default:   state_q <= HEAD_IDLE;
      endcase
    end
  end

  // Operand capture and updated word
  always_ff @(posedge CLK) begin
    if (state_q == HEAD_IDLE && start) begin
      w_q <= weight;
      a_q <= add;
    end
    if (state_q == HEAD_WAIT && mem_rsp.rvalid) begin
      upd_q <= upd_next;
    end
  end

  // Read in HEAD_REQ, write in HEAD_WRITE, same address
  always_comb begin
    mem_req          = '0;
    mem_req.valid    = (state_q == HEAD_REQ) || (state_q == HEAD_WRITE);
    mem_req.we       = (state_q == HEAD_WRITE);
    mem_req.addr.row = row_q;
    mem_req.addr.col = col_q;
    mem_req.wdata    = upd_q;
  end

  // Write-back follows the granted read of that word and its response
  assert property (@(posedge CLK) disable iff (RST)
    $rose(mem_req.valid && mem_req.we) |->
      $past(mem_rsp.rvalid) &&
      $past(gnt && mem_req.valid && !mem_req.we, 2) &&
      ($past(mem_req.addr, 2) == mem_req.addr));

endmodule

`default_nettype wire

//--- source/ntm_reading.sv
`default_nettype none

module ntm_reading (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire ntm_pkg::weight_t      weight,
  output logic                       ready,
  output ntm_mem_pkg::mem_req_t      mem_req,
  input  wire logic                  gnt,
  input  wire ntm_mem_pkg::mem_rsp_t mem_rsp,
  output ntm_pkg::data_t             r_out,
  output logic                       r_out_enable
);
  import ntm_pkg::*;
  import ntm_mem_pkg::*;

  // r[k] = sum over j of w[j] * M[j][k]

  // Control
  head_state_e state_q;
  row_idx_t    row_q;
  col_idx_t    col_q;

  // Data path
  weight_t w_q;
  data_t   word_q;
  data_t   acc_q;
  data_t   acc_next;

  // Product and sum both wrap at 16 bits
  assign acc_next = acc_q + w_q.elem[row_q] * word_q;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= HEAD_IDLE;
      row_q        <= '0;
      col_q        <= '0;
      ready        <= 1'b0;
      r_out_enable <= 1'b0;
    end else begin
      // Strobes last one cycle
      ready        <= 1'b0;
      r_out_enable <= 1'b0;
      case (state_q)
        HEAD_IDLE: begin
          if (start) begin
            row_q   <= '0;
            col_q   <= '0;
            state_q <= HEAD_REQ;
          end
        end
        // Request held until granted
        HEAD_REQ: begin
          if (gnt) begin
            state_q <= HEAD_WAIT;
          end
        end
        HEAD_WAIT: begin
          if (mem_rsp.rvalid) begin
            state_q <= HEAD_ACC;
          end
        end
        HEAD_ACC: begin
          if (row_q == LAST_ROW) begin
            // Column sum complete
            r_out_enable <= 1'b1;
            state_q      <= HEAD_OUT;
          end else begin
            row_q   <= row_q + 1'b1;
            state_q <= HEAD_REQ;
          end
        end
        HEAD_OUT: begin
          row_q <= '0;
          if (col_q == LAST_COL) begin
            ready   <= 1'b1;
            state_q <= HEAD_DONE;
          end else begin
            col_q   <= col_q + 1'b1;
            state_q <= HEAD_REQ;
          end
        end
        // Ready pulse cycle
        HEAD_DONE: state_q <= HEAD_IDLE;
        default:   state_q <= HEAD_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operands and accumulator
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state_q == HEAD_IDLE && start) begin
      w_q   <= weight;
      acc_q <= '0;
    end
    if (state_q == HEAD_WAIT && mem_rsp.rvalid) begin
      word_q <= mem_rsp.rdata;
    end
    if (state_q == HEAD_ACC) begin
      if (row_q == LAST_ROW) begin
        // Present the sum, restart for next column
        r_out <= acc_next;
        acc_q <= '0;
      end else begin
        acc_q <= acc_next;
      end
    end
  end

  // Read-only bus access to M[row][col]
  always_comb begin
    mem_req          = '0;
    mem_req.valid    = (state_q == HEAD_REQ);
    mem_req.addr.row = row_q;
    mem_req.addr.col = col_q;
  end

  // No output strobe from an idle head
  assert property (@(posedge CLK) disable iff (RST)
    r_out_enable |-> (state_q != HEAD_IDLE));

endmodule

`default_nettype wire

//--- source/ntm_memory_arbiter.sv
`default_nettype none

module ntm_memory_arbiter (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire ntm_mem_pkg::mem_req_t rd_req,
  input  wire ntm_mem_pkg::mem_req_t wr_req,
  output logic                       rd_gnt,
  output logic                       wr_gnt,
  output ntm_mem_pkg::mem_rsp_t      rd_rsp,
  output ntm_mem_pkg::mem_rsp_t      wr_rsp,
  output ntm_mem_pkg::mem_req_t      mem_req,
  input  wire ntm_mem_pkg::mem_rsp_t mem_rsp
);
  import ntm_mem_pkg::*;

  // Current winner
  grant_e gnt;
  // Head served most recently
  grant_e last_q;
  // Head waiting on the read in flight
  grant_e owner_q;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin choice
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    gnt = GNT_NONE;
    if (rd_req.valid && wr_req.valid) begin
      // Contention goes to the head not served last
      gnt = (last_q == GNT_READ) ? GNT_WRITE : GNT_READ;
    end else if (rd_req.valid) begin
      gnt = GNT_READ;
    end else if (wr_req.valid) begin
      gnt = GNT_WRITE;
    end
  end

  assign rd_gnt = (gnt == GNT_READ);
  assign wr_gnt = (gnt == GNT_WRITE);

  // Winning request to the memory or an idle bus
  always_comb begin
    case (gnt)
      GNT_READ:  mem_req = rd_req;
      GNT_WRITE: mem_req = wr_req;
      default:   mem_req = '0;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_q  <= GNT_NONE;
      owner_q <= GNT_NONE;
    end else begin
      if (gnt != GNT_NONE) begin
        last_q <= gnt;
      end
      // Only reads produce a response
      owner_q <= (mem_req.valid && !mem_req.we) ? gnt : GNT_NONE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response steering
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_rsp        = mem_rsp;
    wr_rsp        = mem_rsp;
    rd_rsp.rvalid = mem_rsp.rvalid && (owner_q == GNT_READ);
    wr_rsp.rvalid = mem_rsp.rvalid && (owner_q == GNT_WRITE);
  end

  // Grants are exclusive
  assert property (@(posedge CLK) disable iff (RST) !(rd_gnt && wr_gnt));

  // No grant without a pending request
  assert property (@(posedge CLK) disable iff (RST)
    (rd_gnt |-> rd_req.valid) and (wr_gnt |-> wr_req.valid));

endmodule

`default_nettype wire

//--- source/ntm_memory.sv
`default_nettype none

module ntm_memory (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire ntm_mem_pkg::mem_req_t mem_req,
  output ntm_mem_pkg::mem_rsp_t      mem_rsp
);
  import ntm_pkg::*;
  import ntm_mem_pkg::*;

  // Word array indexed by {row, col}
  data_t mem_q [MEM_DEPTH];

  // Read port register
  data_t rdata_q;
  logic  rvalid_q;

  logic  wr_en;
  logic  rd_en;

  assign wr_en = mem_req.valid & mem_req.we;
  assign rd_en = mem_req.valid & ~mem_req.we;

  // Array and response flag, whole matrix clears to zero
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rvalid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        mem_q[mem_req.addr] <= mem_req.wdata;
      end
      rvalid_q <= rd_en;
    end
  end

  // Read data, one cycle latency
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      rdata_q <= mem_q[mem_req.addr];
    end
  end

  assign mem_rsp.rvalid = rvalid_q;
  assign mem_rsp.rdata  = rdata_q;

  // Response only answers a read on the bus one cycle before
  assert property (@(posedge CLK) disable iff (RST)
    mem_rsp.rvalid |-> $past(mem_req.valid && !mem_req.we));

endmodule

`default_nettype wire

//--- source/ntm_mem_pkg.sv
`default_nettype none

package ntm_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Memory bus
  ////////////////////////////////////////////////////////////////////////////

  // Words in the array
  localparam int MEM_DEPTH = ntm_pkg::N_ROWS * ntm_pkg::W_COLS;

  // Row in the upper bits, column in the lower
  typedef struct packed {
    ntm_pkg::row_idx_t row;
    ntm_pkg::col_idx_t col;
  } mem_addr_t;

  // Head to memory
  typedef struct packed {
    logic           valid;
    logic           we;
    mem_addr_t      addr;
    ntm_pkg::data_t wdata;
  } mem_req_t;

  // Memory to head, one cycle after a granted read
  typedef struct packed {
    logic           rvalid;
    ntm_pkg::data_t rdata;
  } mem_rsp_t;

  // Which head holds the bus
  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_READ,
    GNT_WRITE
  } grant_e;

endpackage

`default_nettype wire

//--- source/ntm_pkg.sv
`default_nettype none

package ntm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Matrix shape
  ////////////////////////////////////////////////////////////////////////////

  // Bits per memory word
  localparam int DATA_W = 16;

  // Locations of M and words per location
  localparam int N_ROWS = 8;
  localparam int W_COLS = 4;

  // Index widths
  localparam int ROW_W = $clog2(N_ROWS);
  localparam int COL_W = $clog2(W_COLS);

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ROW_W-1:0]  row_idx_t;
  typedef logic [COL_W-1:0]  col_idx_t;

  // Last index of each loop
  localparam row_idx_t LAST_ROW = row_idx_t'(N_ROWS - 1);
  localparam col_idx_t LAST_COL = col_idx_t'(W_COLS - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Head operands and control
  ////////////////////////////////////////////////////////////////////////////

  // Weighting w, one word per row
  typedef struct packed {
    data_t [N_ROWS-1:0] elem;
  } weight_t;

  // Add vector a, one word per column
  typedef struct packed {
    data_t [W_COLS-1:0] elem;
  } vector_t;

  // Shared by both heads, each uses a subset
  typedef enum logic [2:0] {
    HEAD_IDLE,
    HEAD_REQ,
    HEAD_WAIT,
    HEAD_ACC,
    HEAD_OUT,
    HEAD_WRITE,
    HEAD_DONE
  } head_state_e;

endpackage

`default_nettype wire
